/* flist.f */
hw/csr_pkg.sv
hw/csr_bus_decode.sv
hw/csr_event_decode.sv
hw/csr_masked_reg.sv
hw/csr_counter_bank.sv
hw/csr_read_mux.sv
hw/csr_unit.sv
bench/tb_clock_gen.sv
bench/tb_csr_unit.sv

/* Makefile */
# Verilator build and run for the machine-mode CSR unit

VERILATOR ?= verilator
TOP       ?= tb_csr_unit
FLIST     ?= flist.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

SRCS := $(shell grep -v '^+' $(FLIST))
EXE  := $(BUILD)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(EXE)

$(EXE): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

run: build
	@./$(EXE) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '** FAIL **' $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -qF '** PASS **' $(LOG) || { echo "Simulation did not complete"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD) $(LOG)

/* bench/tb_csr_unit.sv */
/*
 * CSR unit testbench
 * Directed tests over the Wishbone port and the retirement report,
 * each test a task with its own checks
 */
`timescale 1ns/10ps
`default_nettype none

module tb_csr_unit;

   localparam int ACK_TIMEOUT   = 20;
   localparam int RESET_TIMEOUT = 20;

   logic                   clk;
   logic                   arst_n;
   csr_pkg::wb_req_t       wb_req;
   csr_pkg::wb_rsp_t       wb_rsp;
   csr_pkg::retire_info_t  retire;
   int                     errors;
   int                     checks;

   tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(8)) u_clk (.clk(clk), .arst_n(arst_n));

   csr_unit u_dut (
      .clk_in (clk),
      .arst_n (arst_n),
      .wb_req (wb_req),
      .wb_rsp (wb_rsp),
      .retire (retire)
   );

   // --------------------
   // Checks
   task automatic compare_word(input string test, input csr_pkg::word_t exp,
                               input csr_pkg::word_t act);
      checks++;
      assert (act == exp)
      else
      begin
         errors++;
         $display("ERR %s: expected %08h, actual %08h", test, exp, act);
      end
   endtask

   // Strictly larger than a floor value
   task automatic compare_above(input string test, input csr_pkg::word_t floor_val,
                                input csr_pkg::word_t act);
      checks++;
      assert (act > floor_val)
      else
      begin
         errors++;
         $display("ERR %s: expected above %08h, actual %08h", test, floor_val, act);
      end
   endtask

   // --------------------
   // Bus driver drives on the rising edge and samples on the falling edge
   task automatic wb_xfer(input logic we, input logic [csr_pkg::CSR_ADDR_W-1:0] adr,
                          input csr_pkg::word_t wdata, output csr_pkg::word_t rdata);
      int   waited;
      logic got_ack;
      waited  = 0;
      got_ack = 1'b0;
      rdata   = '0;
      @(posedge clk);
      wb_req.cyc <= 1'b1;
      wb_req.stb <= 1'b1;
      wb_req.we  <= we;
      wb_req.adr <= adr;
      wb_req.dat <= wdata;
      while (!got_ack && (waited < ACK_TIMEOUT))
      begin
         @(negedge clk);
         waited++;
         if (wb_rsp.ack)
         begin
            got_ack = 1'b1;
            rdata   = wb_rsp.dat;
         end
      end
      // Drop the strobe in the cycle after ack
      @(posedge clk);
      wb_req.cyc <= 1'b0;
      wb_req.stb <= 1'b0;
      wb_req.we  <= 1'b0;
      checks++;
      assert (got_ack)
      else
      begin
         errors++;
         $display("No acknowledge for address %03h within %0d cycles", adr, ACK_TIMEOUT);
      end
      // Exactly one ack per request
      @(negedge clk);
      checks++;
      assert (!wb_rsp.ack)
      else
      begin
         errors++;
         $display("A second acknowledge came for one request at address %03h", adr);
      end
   endtask

   task automatic wb_write(input logic [csr_pkg::CSR_ADDR_W-1:0] adr,
                           input csr_pkg::word_t data);
      csr_pkg::word_t unused_rd;
      wb_xfer(1'b1, adr, data, unused_rd);
   endtask

   task automatic wb_read(input logic [csr_pkg::CSR_ADDR_W-1:0] adr,
                          output csr_pkg::word_t data);
      wb_xfer(1'b0, adr, '0, data);
   endtask

   task automatic wait_reset_release();
      int waited;
      waited = 0;
      while (!arst_n && (waited < RESET_TIMEOUT))
      begin
         @(posedge clk);
         waited++;
      end
      checks++;
      assert (arst_n)
      else
      begin
         errors++;
         $display("Reset was not released within %0d cycles", RESET_TIMEOUT);
      end
   endtask

   // --------------------
   // Directed tests
   task automatic reset_values();
      csr_pkg::word_t rd;
      // Idle response straight after reset
      @(negedge clk);
      compare_word("reset_values", 32'h0, csr_pkg::word_t'(wb_rsp.ack));
      compare_word("reset_values", 32'h0, wb_rsp.dat);
      wb_read(csr_pkg::ADDR_MSTATUS, rd);
      compare_word("reset_values", 32'h0000_1800, rd);
      wb_read(csr_pkg::ADDR_MTVEC, rd);
      compare_word("reset_values", 32'h0000_0100, rd);
      // RV32IM means MXL 1 with the I and M bits
      wb_read(csr_pkg::ADDR_MISA, rd);
      compare_word("reset_values", 32'h4000_1100, rd);
      // No vendor id and a single hart 0
      wb_read(csr_pkg::ADDR_MVENDORID, rd);
      compare_word("reset_values", 32'h0, rd);
      wb_read(csr_pkg::ADDR_MHARTID, rd);
      compare_word("reset_values", 32'h0, rd);
      // misa ignores writes but still acks
      wb_write(csr_pkg::ADDR_MISA, 32'h0);
      wb_read(csr_pkg::ADDR_MISA, rd);
      compare_word("reset_values", 32'h4000_1100, rd);
   endtask

   // Writable bits take the data and hardwired bits keep the reset value
   task automatic masked_roundtrip(input string test, input logic [11:0] adr,
                                   input csr_pkg::word_t init, input csr_pkg::word_t mask);
      csr_pkg::word_t data;
      csr_pkg::word_t rd;
      data = $urandom();
      wb_write(adr, data);
      wb_read(adr, rd);
      compare_word(test, (data & ~mask) | (init & mask), rd);
   endtask

   task automatic masked_writes();
      for (int n = 0; n < 2; n++)
      begin
         masked_roundtrip("masked_writes", csr_pkg::ADDR_MSCRATCH, 32'h0, 32'h0);
         masked_roundtrip("masked_writes", csr_pkg::ADDR_MTVEC, 32'h100, 32'h2);
         masked_roundtrip("masked_writes", csr_pkg::ADDR_MEPC, 32'h0, 32'h1);
         // Only mie, mpie and mpp
         masked_roundtrip("masked_writes", csr_pkg::ADDR_MSTATUS, 32'h1800, 32'hFFFF_E777);
         // Only meie, mtie and msie with the upper bits reading zero
         masked_roundtrip("masked_writes", csr_pkg::ADDR_MIE, 32'h0, 32'hFFFF_F777);
      end
   endtask

   task automatic bus_protocol();
      csr_pkg::word_t rd;
      wb_read(12'h7C0, rd);
      compare_word("bus_protocol", 32'h0, rd);
      // Write to a hole is acked and leaves nothing behind
      wb_write(12'h123, 32'hDEAD_BEEF);
      wb_read(12'h123, rd);
      compare_word("bus_protocol", 32'h0, rd);
   endtask

   task automatic instret_inhibit();
      csr_pkg::word_t rd;
      csr_pkg::word_t first;
      localparam int N_RET = 13;
      wb_write(csr_pkg::ADDR_MINSTRET, 32'h0);
      wb_write(csr_pkg::ADDR_MINSTRETH, 32'h0);
      // One retirement every other cycle
      for (int k = 0; k < N_RET; k++)
      begin
         @(posedge clk);
         retire.ret_valid <= 1'b1;
         retire.ret_class <= csr_pkg::RET_ALU;
         @(posedge clk);
         retire.ret_valid <= 1'b0;
      end
      wb_read(csr_pkg::ADDR_MINSTRET, rd);
      compare_word("instret_inhibit", 32'(N_RET), rd);
      // Freeze mcycle
      wb_write(csr_pkg::ADDR_MCOUNTINHIBIT, 32'h1);
      wb_read(csr_pkg::ADDR_MCYCLE, first);
      wb_read(csr_pkg::ADDR_MCYCLE, rd);
      compare_word("instret_inhibit", first, rd);
      wb_write(csr_pkg::ADDR_MCOUNTINHIBIT, 32'h0);
      wb_read(csr_pkg::ADDR_MCYCLE, rd);
      compare_above("instret_inhibit", first, rd);
   endtask

   task automatic event_counts();
      csr_pkg::retire_info_t info;
      csr_pkg::word_t        rd;
      int                    exp_jump;
      int                    exp_misalign;
      exp_jump     = 0;
      exp_misalign = 0;
      // hpm3 counts control transfers and hpm4 misaligned exceptions
      wb_write(csr_pkg::ADDR_MHPMEVENT3, 32'd11);
      wb_write(12'h324, 32'd12);
      wb_write(csr_pkg::ADDR_MHPMCOUNTER3, 32'h0);
      wb_write(csr_pkg::ADDR_MHPMCOUNTER3H, 32'h0);
      wb_write(12'hB04, 32'h0);
      wb_write(12'hB84, 32'h0);
      for (int i = 0; i < 30; i++)
      begin
         info           = '0;
         info.ret_valid = (i % 3) != 2;
         info.ret_class = csr_pkg::ret_class_e'(i % 10);
         info.exc_valid = (i % 4) == 0;
         info.exc_cause = 4'((i / 4) % 8);
         if (info.ret_valid && (info.ret_class inside
             {csr_pkg::RET_BRANCH, csr_pkg::RET_JAL, csr_pkg::RET_JALR}))
            exp_jump++;
         if (info.exc_valid && (info.exc_cause inside {4'd0, 4'd4, 4'd6}))
            exp_misalign++;
         @(posedge clk);
         retire <= info;
      end
      @(posedge clk);
      retire <= '0;
      wb_read(csr_pkg::ADDR_MHPMCOUNTER3, rd);
      compare_word("event_counts", 32'(exp_jump), rd);
      wb_read(12'hB04, rd);
      compare_word("event_counts", 32'(exp_misalign), rd);
   endtask

   task automatic irq_pending();
      csr_pkg::word_t rd;
      @(posedge clk);
      retire.ext_irq <= 1'b1;
      wb_read(csr_pkg::ADDR_MIP, rd);
      compare_word("irq_pending", 32'h1 << 11, rd);
      @(posedge clk);
      retire.ext_irq <= 1'b0;
      wb_read(csr_pkg::ADDR_MIP, rd);
      compare_word("irq_pending", 32'h0, rd);
   endtask

   // --------------------
   // Sequence and closing report
   initial
   begin
      wb_req <= '0;
      retire <= '0;
      errors = 0;
      checks = 0;
      void'($urandom(97));
      wait_reset_release();
      reset_values();
      masked_writes();
      bus_protocol();
      instret_inhibit();
      event_counts();
      irq_pending();
      repeat (2) @(posedge clk);
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire

/* bench/tb_clock_gen.sv */
/*
 * Testbench clock and reset
 * 100 ns clock, reset held low for the first 8 cycles
 */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen
#(
   parameter int PERIOD_NS    = 100,
   parameter int RESET_CYCLES = 8
)
(
   output logic clk,
   output logic arst_n
);

   // Free-running clock
   initial
   begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // Release on a rising edge
   initial
   begin
      arst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      arst_n <= 1'b1;
   end

endmodule

`default_nettype wire

/* hw/csr_unit.sv */
/*
 * Machine-mode CSR unit
 * Wishbone classic slave for the RV32 machine-mode CSRs,
 * counters and performance events
 */
`timescale 1ns/10ps
`default_nettype none

module csr_unit
(
   input  logic                   clk_in,
   input  logic                   arst_n,
   input  csr_pkg::wb_req_t       wb_req,
   output csr_pkg::wb_rsp_t       wb_rsp,
   input  csr_pkg::retire_info_t  retire
);

   csr_pkg::csr_sel_e                         sel;
   csr_pkg::csr_wr_t                          wr;
   logic                                      ack;
   csr_pkg::hpm_events_t                      events;
   csr_pkg::csr_file_t                        regs;
   csr_pkg::word_t [2*csr_pkg::NUM_CNT-1:0]   cnt_rd;
   csr_pkg::ev_sel_t [csr_pkg::NUM_HPM-1:0]   hpm_sel;
   logic                                      meip;

   // --------------------
   // Decode
   csr_bus_decode u_decode (
      .clk_in (clk_in),
      .arst_n (arst_n),
      .wb_req (wb_req),
      .sel    (sel),
      .wr     (wr),
      .ack    (ack)
   );

   csr_event_decode u_events (
      .retire (retire),
      .events (events)
   );

   // --------------------
   // Execute, software-writable registers
   csr_masked_reg #(.data_t(csr_pkg::mstatus_t), .INIT(csr_pkg::MSTATUS_INIT),
      .MASK(csr_pkg::MSTATUS_MASK), .SEL(csr_pkg::SEL_MSTATUS))
      u_mstatus (.clk_in(clk_in), .arst_n(arst_n), .wr(wr), .q(regs.mstatus));

   csr_masked_reg #(.data_t(csr_pkg::mi_t), .INIT(csr_pkg::MIE_INIT),
      .MASK(csr_pkg::MIE_MASK), .SEL(csr_pkg::SEL_MIE))
      u_mie (.clk_in(clk_in), .arst_n(arst_n), .wr(wr), .q(regs.mie));

   // Vectored or direct mode only
   csr_masked_reg #(.data_t(csr_pkg::word_t), .INIT(csr_pkg::MTVEC_INIT),
      .MASK(csr_pkg::MTVEC_MASK), .SEL(csr_pkg::SEL_MTVEC))
      u_mtvec (.clk_in(clk_in), .arst_n(arst_n), .wr(wr), .q(regs.mtvec));

   csr_masked_reg #(.data_t(csr_pkg::word_t), .INIT(csr_pkg::MSCRATCH_INIT),
      .MASK(csr_pkg::NO_MASK), .SEL(csr_pkg::SEL_MSCRATCH))
      u_mscratch (.clk_in(clk_in), .arst_n(arst_n), .wr(wr), .q(regs.mscratch));

   // Bit 0 stays clear
   csr_masked_reg #(.data_t(csr_pkg::word_t), .INIT(csr_pkg::MEPC_INIT),
      .MASK(csr_pkg::MEPC_MASK), .SEL(csr_pkg::SEL_MEPC))
      u_mepc (.clk_in(clk_in), .arst_n(arst_n), .wr(wr), .q(regs.mepc));

   csr_masked_reg #(.data_t(csr_pkg::word_t), .INIT(csr_pkg::MCAUSE_INIT),
      .MASK(csr_pkg::NO_MASK), .SEL(csr_pkg::SEL_MCAUSE))
      u_mcause (.clk_in(clk_in), .arst_n(arst_n), .wr(wr), .q(regs.mcause));

   csr_masked_reg #(.data_t(csr_pkg::word_t), .INIT(csr_pkg::MTVAL_INIT),
      .MASK(csr_pkg::NO_MASK), .SEL(csr_pkg::SEL_MTVAL))
      u_mtval (.clk_in(clk_in), .arst_n(arst_n), .wr(wr), .q(regs.mtval));

   csr_masked_reg #(.data_t(csr_pkg::word_t), .INIT(csr_pkg::MINHIBIT_INIT),
      .MASK(csr_pkg::MINHIBIT_MASK), .SEL(csr_pkg::SEL_MINHIBIT))
      u_minhibit (.clk_in(clk_in), .arst_n(arst_n), .wr(wr), .q(regs.minhibit));

   csr_counter_bank u_counters (
      .clk_in    (clk_in),
      .arst_n    (arst_n),
      .wr        (wr),
      .inhibit   (regs.minhibit),
      .events    (events),
      .ret_valid (retire.ret_valid),
      .cnt_rd    (cnt_rd),
      .hpm_sel   (hpm_sel)
   );

   // External interrupt pending, sampled once
   always_ff @(posedge clk_in or negedge arst_n)
   begin
      if (!arst_n)
         meip <= 1'b0;
      else
         meip <= retire.ext_irq;
   end

   // --------------------
   // Result
   csr_read_mux u_read (
      .clk_in  (clk_in),
      .arst_n  (arst_n),
      .sel     (sel),
      .ack     (ack),
      .regs    (regs),
      .cnt_rd  (cnt_rd),
      .hpm_sel (hpm_sel),
      .meip    (meip),
      .rdata   (wb_rsp.dat)
   );

   assign wb_rsp.ack = ack;

endmodule

`default_nettype wire

/* hw/csr_read_mux.sv */
/*
 * CSR read mux
 * Picks the addressed word and registers it so it is
 * presented together with the bus acknowledge
 */
`timescale 1ns/10ps
`default_nettype none

module csr_read_mux
(
   input  logic                                     clk_in,
   input  logic                                     arst_n,
   input  csr_pkg::csr_sel_e                        sel,
   input  logic                                     ack,
   input  csr_pkg::csr_file_t                       regs,
   input  csr_pkg::word_t [2*csr_pkg::NUM_CNT-1:0]  cnt_rd,
   input  csr_pkg::ev_sel_t [csr_pkg::NUM_HPM-1:0]  hpm_sel,
   input  logic                                     meip,
   output csr_pkg::word_t                           rdata
);

   csr_pkg::word_t rd_d;

   always_comb
   begin
      // Holes read zero
      rd_d = '0;
      case (sel)
         csr_pkg::SEL_MSTATUS:   rd_d = csr_pkg::word_t'(regs.mstatus);
         csr_pkg::SEL_MISA:      rd_d = csr_pkg::MISA_VAL;
         csr_pkg::SEL_MIE:       rd_d = csr_pkg::XLEN'(regs.mie);
         csr_pkg::SEL_MTVEC:     rd_d = regs.mtvec;
         csr_pkg::SEL_MINHIBIT:  rd_d = regs.minhibit;
         csr_pkg::SEL_MSCRATCH:  rd_d = regs.mscratch;
         csr_pkg::SEL_MEPC:      rd_d = regs.mepc;
         csr_pkg::SEL_MCAUSE:    rd_d = regs.mcause;
         csr_pkg::SEL_MTVAL:     rd_d = regs.mtval;
         csr_pkg::SEL_MIP:       rd_d[csr_pkg::MEIP_BIT] = meip;
         csr_pkg::SEL_MVENDORID: rd_d = csr_pkg::MVENDORID_VAL;
         csr_pkg::SEL_MARCHID:   rd_d = csr_pkg::MARCHID_VAL;
         csr_pkg::SEL_MIMPID:    rd_d = csr_pkg::MIMPID_VAL;
         csr_pkg::SEL_MHARTID:   rd_d = csr_pkg::MHARTID_VAL;
         default:                rd_d = '0;
      endcase
      // Event selectors, zero extended
      for (int k = 0; k < csr_pkg::NUM_HPM; k++)
      begin
         if (sel == csr_pkg::csr_sel_e'(csr_pkg::SEL_MHPMEVENT3 + k))
            rd_d = csr_pkg::XLEN'(hpm_sel[k]);
      end
      // Counter halves in select order
      for (int h = 0; h < 2 * csr_pkg::NUM_CNT; h++)
      begin
         if (sel == csr_pkg::csr_sel_e'(csr_pkg::SEL_MCYCLE + h))
            rd_d = cnt_rd[h];
      end
   end

   // --------------------
   // Capture on the request cycle, the ack cycle carries the word
   always_ff @(posedge clk_in or negedge arst_n)
   begin
      if (!arst_n)
         rdata <= '0;
      else if (ack)
         rdata <= '0;
      else
         rdata <= rd_d;
   end

endmodule

`default_nettype wire

/* hw/csr_counter_bank.sv */
/*
 * Counter bank
 * mcycle, minstret and mhpmcounter3..6 with their event selectors,
 * count inhibit and software write priority over counting
 */
`timescale 1ns/10ps
`default_nettype none

module csr_counter_bank
(
   input  logic                                          clk_in,
   input  logic                                          arst_n,
   input  csr_pkg::csr_wr_t                              wr,
   input  csr_pkg::word_t                                inhibit,
   input  csr_pkg::hpm_events_t                          events,
   input  logic                                          ret_valid,
   output csr_pkg::word_t [2*csr_pkg::NUM_CNT-1:0]       cnt_rd,
   output csr_pkg::ev_sel_t [csr_pkg::NUM_HPM-1:0]       hpm_sel
);

   logic [csr_pkg::NUM_CNT-1:0][2*csr_pkg::XLEN-1:0] cnt_q;
   logic [csr_pkg::NUM_CNT-1:0]                      inc;
   logic [csr_pkg::NUM_CNT-1:0]                      wr_lo;
   logic [csr_pkg::NUM_CNT-1:0]                      wr_hi;

   // Inhibit bit 1 is the unused time slot
   assign inc[0] = ~inhibit[0];
   assign inc[1] = ret_valid & ~inhibit[2];

   // --------------------
   // Event selectors and hpm count enables
   for (genvar k = 0; k < csr_pkg::NUM_HPM; k++)
   begin : g_hpm
      assign inc[2+k] = events[hpm_sel[k]] & ~inhibit[3+k];

      always_ff @(posedge clk_in or negedge arst_n)
      begin
         if (!arst_n)
            hpm_sel[k] <= '0;
         else if (wr.en && (wr.sel == csr_pkg::csr_sel_e'(csr_pkg::SEL_MHPMEVENT3 + k)))
            hpm_sel[k] <= wr.data[csr_pkg::EV_SEL_W-1:0];
      end
   end

   // --------------------
   // 64-bit counters, halves laid out low then high
   for (genvar c = 0; c < csr_pkg::NUM_CNT; c++)
   begin : g_cnt
      assign wr_lo[c] = wr.en && (wr.sel == csr_pkg::csr_sel_e'(csr_pkg::SEL_MCYCLE + 2 * c));
      assign wr_hi[c] = wr.en && (wr.sel == csr_pkg::csr_sel_e'(csr_pkg::SEL_MCYCLEH + 2 * c));

      assign cnt_rd[2*c]   = cnt_q[c][csr_pkg::XLEN-1:0];
      assign cnt_rd[2*c+1] = cnt_q[c][2*csr_pkg::XLEN-1:csr_pkg::XLEN];

      // A write to either half drops this cycle's increment
      always_ff @(posedge clk_in or negedge arst_n)
      begin
         if (!arst_n)
            cnt_q[c] <= '0;
         else if (wr_lo[c])
            cnt_q[c][csr_pkg::XLEN-1:0] <= wr.data;
         else if (wr_hi[c])
            cnt_q[c][2*csr_pkg::XLEN-1:csr_pkg::XLEN] <= wr.data;
         else if (inc[c])
            cnt_q[c] <= cnt_q[c] + 1'b1;
      end
   end

endmodule

`default_nettype wire

/* hw/csr_masked_reg.sv */
/*
 * Masked CSR
 * One software-writable register, generic in its payload type,
 * whose hardwired bits always hold the reset value
 */
`timescale 1ns/10ps
`default_nettype none

module csr_masked_reg
#(
   parameter type               data_t = csr_pkg::word_t,
   parameter data_t             INIT   = '0,
   parameter data_t             MASK   = '0,
   parameter csr_pkg::csr_sel_e SEL    = csr_pkg::SEL_NONE
)
(
   input  logic              clk_in,
   input  logic              arst_n,
   input  csr_pkg::csr_wr_t  wr,
   output data_t             q
);

   localparam int           W      = $bits(data_t);
   localparam logic [W-1:0] INIT_V = INIT;
   localparam logic [W-1:0] MASK_V = MASK;

   logic [W-1:0] d;

   // Writable bits from the bus, masked bits from reset
   assign d = (wr.data[W-1:0] & ~MASK_V) | (INIT_V & MASK_V);

   always_ff @(posedge clk_in or negedge arst_n)
   begin
      if (!arst_n)
         q <= INIT;
      else if (wr.en && (wr.sel == SEL))
         q <= data_t'(d);
   end

endmodule

`default_nettype wire

/* hw/csr_event_decode.sv */
/*
 * Performance event decode
 * Turns the per-cycle retirement report into the
 * event vector used by the hpm counters
 */
`timescale 1ns/10ps
`default_nettype none

module csr_event_decode
(
   input  csr_pkg::retire_info_t  retire,
   output csr_pkg::hpm_events_t   events
);

   logic is_jump;
   logic is_misalign;

   // Any control transfer
   assign is_jump = retire.ret_valid &
                    ((retire.ret_class == csr_pkg::RET_BRANCH) |
                     (retire.ret_class == csr_pkg::RET_JAL) |
                     (retire.ret_class == csr_pkg::RET_JALR));

   // Instruction, load or store address misaligned
   assign is_misalign = retire.exc_valid &
                        ((retire.exc_cause == 4'd0) |
                         (retire.exc_cause == 4'd4) |
                         (retire.exc_cause == 4'd6));

   always_comb
   begin
      // Event 0 never counts
      events = '0;
      // Events 1 to 10 are one per retirement class
      for (int i = 0; i < 10; i++)
      begin
         events[i+1] = retire.ret_valid &&
                       (retire.ret_class == csr_pkg::ret_class_e'(i));
      end
      events[11] = is_jump;
      events[12] = is_misalign;
      // Illegal instruction
      events[13] = retire.exc_valid & (retire.exc_cause == 4'd2);
      events[14] = retire.ext_irq;
      events[15] = retire.ret_valid;
   end

endmodule

`default_nettype wire

/* hw/csr_bus_decode.sv */
/*
 * CSR bus decode
 * Maps a Wishbone classic request onto a register select,
 * builds the write strobe and makes the one-cycle acknowledge
 */
`timescale 1ns/10ps
`default_nettype none

module csr_bus_decode
(
   input  logic               clk_in,
   input  logic               arst_n,
   input  csr_pkg::wb_req_t   wb_req,
   output csr_pkg::csr_sel_e  sel,
   output csr_pkg::csr_wr_t   wr,
   output logic               ack
);

   logic               req_act;
   logic               writable;
   csr_pkg::csr_sel_e  map_sel;

   assign req_act = wb_req.cyc & wb_req.stb;

   // --------------------
   // Address map
   always_comb
   begin
      map_sel = csr_pkg::SEL_NONE;
      case (wb_req.adr)
         csr_pkg::ADDR_MSTATUS:       map_sel = csr_pkg::SEL_MSTATUS;
         csr_pkg::ADDR_MISA:          map_sel = csr_pkg::SEL_MISA;
         csr_pkg::ADDR_MIE:           map_sel = csr_pkg::SEL_MIE;
         csr_pkg::ADDR_MTVEC:         map_sel = csr_pkg::SEL_MTVEC;
         csr_pkg::ADDR_MCOUNTINHIBIT: map_sel = csr_pkg::SEL_MINHIBIT;
         csr_pkg::ADDR_MSCRATCH:      map_sel = csr_pkg::SEL_MSCRATCH;
         csr_pkg::ADDR_MEPC:          map_sel = csr_pkg::SEL_MEPC;
         csr_pkg::ADDR_MCAUSE:        map_sel = csr_pkg::SEL_MCAUSE;
         csr_pkg::ADDR_MTVAL:         map_sel = csr_pkg::SEL_MTVAL;
         csr_pkg::ADDR_MIP:           map_sel = csr_pkg::SEL_MIP;
         csr_pkg::ADDR_MCYCLE:        map_sel = csr_pkg::SEL_MCYCLE;
         csr_pkg::ADDR_MCYCLEH:       map_sel = csr_pkg::SEL_MCYCLEH;
         csr_pkg::ADDR_MINSTRET:      map_sel = csr_pkg::SEL_MINSTRET;
         csr_pkg::ADDR_MINSTRETH:     map_sel = csr_pkg::SEL_MINSTRETH;
         csr_pkg::ADDR_MVENDORID:     map_sel = csr_pkg::SEL_MVENDORID;
         csr_pkg::ADDR_MARCHID:       map_sel = csr_pkg::SEL_MARCHID;
         csr_pkg::ADDR_MIMPID:        map_sel = csr_pkg::SEL_MIMPID;
         csr_pkg::ADDR_MHARTID:       map_sel = csr_pkg::SEL_MHARTID;
         default:                     map_sel = csr_pkg::SEL_NONE;
      endcase
      // hpm selectors and counters sit on address ranges
      for (int k = 0; k < csr_pkg::NUM_HPM; k++)
      begin
         if (wb_req.adr == csr_pkg::CSR_ADDR_W'(csr_pkg::ADDR_MHPMEVENT3 + k))
            map_sel = csr_pkg::csr_sel_e'(csr_pkg::SEL_MHPMEVENT3 + k);
         if (wb_req.adr == csr_pkg::CSR_ADDR_W'(csr_pkg::ADDR_MHPMCOUNTER3 + k))
            map_sel = csr_pkg::csr_sel_e'(csr_pkg::SEL_MHPMCNT3 + 2 * k);
         if (wb_req.adr == csr_pkg::CSR_ADDR_W'(csr_pkg::ADDR_MHPMCOUNTER3H + k))
            map_sel = csr_pkg::csr_sel_e'(csr_pkg::SEL_MHPMCNT3H + 2 * k);
      end
   end

   // Constants, mip and holes take no write
   always_comb
   begin
      case (map_sel)
         csr_pkg::SEL_NONE, csr_pkg::SEL_MISA, csr_pkg::SEL_MIP,
         csr_pkg::SEL_MVENDORID, csr_pkg::SEL_MARCHID,
         csr_pkg::SEL_MIMPID, csr_pkg::SEL_MHARTID: writable = 1'b0;
         default:                                   writable = 1'b1;
      endcase
   end

   // --------------------
   // Select only while a request is on the bus
   assign sel = req_act ? map_sel : csr_pkg::SEL_NONE;

   // Strobe lands on the edge where ack rises
   always_comb
   begin
      wr.sel  = sel;
      wr.en   = req_act & ~ack & wb_req.we & writable;
      wr.data = wb_req.dat;
   end

   // One ack per request, then a gap cycle
   always_ff @(posedge clk_in or negedge arst_n)
   begin
      if (!arst_n)
         ack <= 1'b0;
      else
         ack <= req_act & ~ack;
   end

endmodule

`default_nettype wire

/* hw/csr_pkg.sv */
/*
 * Machine-mode CSR unit shared definitions
 * Widths, CSR addresses, reset values, hardwired-bit masks,
 * register selects and the bus and retirement structs
 */
`default_nettype none

package csr_pkg;

   // --------------------
   // Widths and counts
   localparam int XLEN       = 32;
   localparam int CSR_ADDR_W = 12;
   localparam int NUM_HPM    = 4;
   localparam int NUM_EVENTS = 16;
   localparam int EV_SEL_W   = 4;
   localparam int MI_W       = 12;
   // mcycle, minstret and the hpm counters
   localparam int NUM_CNT    = 2 + NUM_HPM;
   localparam int MEIP_BIT   = 11;

   // --------------------
   // Standard RISC-V machine-mode addresses
   localparam logic [CSR_ADDR_W-1:0] ADDR_MSTATUS       = 12'h300;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MISA          = 12'h301;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MIE           = 12'h304;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MTVEC         = 12'h305;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MCOUNTINHIBIT = 12'h320;
   // mhpmevent3..6 follow on consecutive addresses
   localparam logic [CSR_ADDR_W-1:0] ADDR_MHPMEVENT3    = 12'h323;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MSCRATCH      = 12'h340;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MEPC          = 12'h341;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MCAUSE        = 12'h342;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MTVAL         = 12'h343;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MIP           = 12'h344;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MCYCLE        = 12'hB00;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MINSTRET      = 12'hB02;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MHPMCOUNTER3  = 12'hB03;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MCYCLEH       = 12'hB80;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MINSTRETH     = 12'hB82;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MHPMCOUNTER3H = 12'hB83;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MVENDORID     = 12'hF11;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MARCHID       = 12'hF12;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MIMPID        = 12'hF13;
   localparam logic [CSR_ADDR_W-1:0] ADDR_MHARTID       = 12'hF14;

   // --------------------
   // Basic types
   typedef logic [XLEN-1:0]       word_t;
   typedef logic [MI_W-1:0]       mi_t;
   typedef logic [NUM_EVENTS-1:0] hpm_events_t;
   typedef logic [EV_SEL_W-1:0]   ev_sel_t;

   // Reset values, mpp starts in machine mode
   localparam word_t MSTATUS_INIT  = 32'h0000_1800;
   localparam mi_t   MIE_INIT      = '0;
   localparam word_t MTVEC_INIT    = 32'h0000_0100;
   localparam word_t MSCRATCH_INIT = '0;
   localparam word_t MEPC_INIT     = '0;
   localparam word_t MCAUSE_INIT   = '0;
   localparam word_t MTVAL_INIT    = '0;
   localparam word_t MINHIBIT_INIT = '0;

   // Read-only constants, misa is MXL=1 with I and M
   localparam word_t MISA_VAL      = 32'h4000_1100;
   localparam word_t MVENDORID_VAL = '0;
   localparam word_t MARCHID_VAL   = '0;
   localparam word_t MIMPID_VAL    = '0;
   localparam word_t MHARTID_VAL   = '0;

   // Hardwired bits, a one keeps the reset value
   localparam word_t NO_MASK       = '0;
   localparam word_t MSTATUS_MASK  = 32'hFFFF_E777;
   localparam mi_t   MIE_MASK      = 12'h777;
   localparam word_t MTVEC_MASK    = 32'h0000_0002;
   localparam word_t MEPC_MASK     = 32'h0000_0001;
   localparam word_t MINHIBIT_MASK = 32'hFFFF_FF82;

   // --------------------
   // mstatus with only mie, mpie and mpp kept
   typedef struct packed {
      logic [18:0] rsv_hi;
      logic [1:0]  mpp;
      logic [2:0]  rsv_mid;
      logic        mpie;
      logic [2:0]  rsv_lo;
      logic        mie;
      logic [2:0]  rsv_0;
   } mstatus_t;

   // Counter halves and event selectors are kept consecutive
   typedef enum logic [5:0] {
      SEL_NONE, SEL_MSTATUS, SEL_MISA, SEL_MIE, SEL_MTVEC, SEL_MINHIBIT,
      SEL_MHPMEVENT3, SEL_MHPMEVENT4, SEL_MHPMEVENT5, SEL_MHPMEVENT6,
      SEL_MSCRATCH, SEL_MEPC, SEL_MCAUSE, SEL_MTVAL, SEL_MIP,
      SEL_MCYCLE, SEL_MCYCLEH, SEL_MINSTRET, SEL_MINSTRETH,
      SEL_MHPMCNT3, SEL_MHPMCNT3H, SEL_MHPMCNT4, SEL_MHPMCNT4H,
      SEL_MHPMCNT5, SEL_MHPMCNT5H, SEL_MHPMCNT6, SEL_MHPMCNT6H,
      SEL_MVENDORID, SEL_MARCHID, SEL_MIMPID, SEL_MHARTID
   } csr_sel_e;

   typedef enum logic [3:0] {
      RET_LOAD   = 4'd0,
      RET_STORE  = 4'd1,
      RET_ALU    = 4'd2,
      RET_BRANCH = 4'd3,
      RET_JAL    = 4'd4,
      RET_JALR   = 4'd5,
      RET_MUL    = 4'd6,
      RET_DIV    = 4'd7,
      RET_CSR    = 4'd8,
      RET_SYS    = 4'd9
   } ret_class_e;

   typedef struct packed {
      logic       ret_valid;
      ret_class_e ret_class;
      logic       exc_valid;
      logic [3:0] exc_cause;
      logic       ext_irq;
   } retire_info_t;

   // Wishbone classic request and response
   typedef struct packed {
      logic                  cyc;
      logic                  stb;
      logic                  we;
      logic [CSR_ADDR_W-1:0] adr;
      word_t                 dat;
   } wb_req_t;

   typedef struct packed {
      word_t dat;
      logic  ack;
   } wb_rsp_t;

   typedef struct packed {
      csr_sel_e sel;
      logic     en;
      word_t    data;
   } csr_wr_t;

   // Software-writable register file outputs
   typedef struct packed {
      mstatus_t mstatus;
      mi_t      mie;
      word_t    mtvec;
      word_t    mscratch;
      word_t    mepc;
      word_t    mcause;
      word_t    mtval;
      word_t    minhibit;
   } csr_file_t;

endpackage

`default_nettype wire
